//--- Bender.yml
package:
  name: zx_memctl

dependencies: {}

sources:
  - files:
      - verilog/zx_pkg.sv
      - verilog/zbus_if.sv
      - verilog/zsignals.sv
      - verilog/zports.sv
      - verilog/pager.sv
      - verilog/zx_memctl_top.sv
  - target: test
    files:
      - testbench/tb_zx_memctl.sv

//--- build.f
verilog/zx_pkg.sv
verilog/zbus_if.sv
verilog/zsignals.sv
verilog/zports.sv
verilog/pager.sv
verilog/zx_memctl_top.sv
testbench/tb_zx_memctl.sv

//--- testbench/tb_zx_memctl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zx_memctl;
	import zx_pkg::*;

	localparam int N_TXN       = 400;
	localparam int RST_CYC     = 16;
	localparam int TIMEOUT_CYC = N_TXN * 14 + RST_CYC + 50;

	logic                fclk;
	logic                rst_n;
	logic                iorq_n;
	logic                mreq_n;
	logic                rd_n;
	logic                wr_n;
	logic                m1_n;
	addr_t               a;
	data_t               d_in;
	data_t               d_out;
	logic                d_oe;
	page_t               page;
	logic                csrom;
	logic                rw_en;
	logic [TURBO_W-1:0]  turbo;

	// reference copies of the six registers
	page_t page_m [4];
	data_t sysconf_m;
	data_t memconf_m;

	int n_checks = 0;
	int n_errors = 0;
	int txn_cnt  = 0;
	int cycles   = 0;

	zx_memctl_top u_zx_memctl_top (
		.fclk   (fclk),
		.rst_n  (rst_n),
		.iorq_n (iorq_n),
		.mreq_n (mreq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.a      (a),
		.d_in   (d_in),
		.d_out  (d_out),
		.d_oe   (d_oe),
		.page   (page),
		.csrom  (csrom),
		.rw_en  (rw_en),
		.turbo  (turbo)
	);

	initial fclk = 1'b0;
	always #10 fclk = ~fclk;

	always @(posedge fclk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("timeout after %0d cycles, the test sequence did not complete", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic logic is_hit(addr_t ad);
		case (ad[15:8])
			REG_PAGE0, REG_PAGE1, REG_PAGE2, REG_PAGE3, REG_SYSCONF, REG_MEMCONF:
				is_hit = ad[7:0] == XT_PORT_LO;
			default:
				is_hit = 1'b0;
		endcase
	endfunction

	function automatic data_t model_value(addr_t ad);
		case (ad[15:8])
			REG_PAGE0:   return page_m[0];
			REG_PAGE1:   return page_m[1];
			REG_PAGE2:   return page_m[2];
			REG_PAGE3:   return page_m[3];
			REG_SYSCONF: return sysconf_m;
			REG_MEMCONF: return memconf_m;
			default:     return '0;
		endcase
	endfunction

	task automatic model_write(addr_t ad, data_t dv);
		if (is_hit(ad)) begin
			case (ad[15:8])
				REG_PAGE0:   page_m[0] = dv;
				REG_PAGE1:   page_m[1] = dv;
				REG_PAGE2:   page_m[2] = dv;
				REG_PAGE3:   page_m[3] = dv;
				REG_SYSCONF: sysconf_m = dv;
				default:     memconf_m = dv;
			endcase
		end
	endtask

	function automatic data_t reg_hi(int idx);
		case (idx)
			0:       return REG_PAGE0;
			1:       return REG_PAGE1;
			2:       return REG_PAGE2;
			3:       return REG_PAGE3;
			4:       return REG_SYSCONF;
			default: return REG_MEMCONF;
		endcase
	endfunction

	function automatic data_t unused_hi();
		data_t h;
		h = data_t'($urandom);
		while (is_hit({h, XT_PORT_LO}))
			h = data_t'($urandom);
		return h;
	endfunction

	// registers most of the time, some misses of both kinds
	function automatic addr_t pick_port();
		int    kind;
		data_t lo;
		kind = $urandom % 8;
		if (kind < 6)
			return {reg_hi(kind), XT_PORT_LO};
		if (kind == 6) begin
			lo = data_t'($urandom);
			if (lo == XT_PORT_LO)
				lo = 8'hAE;
			return {reg_hi($urandom % 6), lo};
		end
		return {unused_hi(), XT_PORT_LO};
	endfunction

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_page(string name, page_t exp, page_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_data(string name, data_t exp, data_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_turbo(string name, logic [TURBO_W-1:0] exp, logic [TURBO_W-1:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("ERR %s expected %h got %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_map(addr_t ad);
		win_t w;
		logic rom_exp;
		logic we_exp;
		w       = ad[ADDR_W-1 -: WIN_W];
		rom_exp = (w == '0) && !memconf_m[MC_W0_RAM];
		we_exp  = !(rom_exp && !memconf_m[MC_W0_WE]);
		check_page("page", page_m[w], page);
		check_flag("csrom", rom_exp, csrom);
		check_flag("rw_en", we_exp, rw_en);
		check_turbo("turbo", sysconf_m[TURBO_W-1:0], turbo);
		check_flag("d_oe", 1'b0, d_oe);
	endtask

	////////////////////////////////////////////////////////////
	// bus cycles, entered and left on a falling edge
	////////////////////////////////////////////////////////////

	task automatic idle_bus(int n);
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		repeat (n) @(negedge fclk);
	endtask

	task automatic io_write(addr_t ad, data_t dv);
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		rd_n   = 1'b1;
		mreq_n = 1'b1;
		m1_n   = 1'b1;
		a      = ad;
		d_in   = dv;
		model_write(ad, dv);
		// strobe at edge 3, register at edge 4
		repeat (4) @(negedge fclk);
		check_turbo("turbo", sysconf_m[TURBO_W-1:0], turbo);
		repeat (2) @(negedge fclk);
		txn_cnt++;
		idle_bus(4 + $urandom % 3);
	endtask

	task automatic io_read(addr_t ad);
		logic hit;
		hit    = is_hit(ad);
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		wr_n   = 1'b1;
		mreq_n = 1'b1;
		m1_n   = 1'b1;
		a      = ad;
		d_in   = data_t'($urandom);
		for (int i = 1; i <= 4; i++) begin
			@(negedge fclk);
			if (!hit) begin
				check_flag("d_oe", 1'b0, d_oe);
			end else if (i >= 2) begin
				check_flag("d_oe", 1'b1, d_oe);
				check_data("d_out", model_value(ad), d_out);
			end
		end
		txn_cnt++;
		idle_bus(4 + $urandom % 3);
	endtask

	task automatic mem_access(addr_t ad);
		logic wr;
		wr     = $urandom % 2;
		mreq_n = 1'b0;
		iorq_n = 1'b1;
		rd_n   = wr;
		wr_n   = !wr;
		m1_n   = $urandom % 2;
		a      = ad;
		d_in   = data_t'($urandom);
		repeat (3) @(negedge fclk);
		check_map(ad);
		txn_cnt++;
		idle_bus(4 + $urandom % 3);
	endtask

	initial begin
		addr_t ad;
		int    kind;
		void'($urandom(32'hd370));
		rst_n  = 1'b0;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		a      = '0;
		d_in   = '0;
		page_m[0] = PAGE0_RST;
		page_m[1] = PAGE1_RST;
		page_m[2] = PAGE2_RST;
		page_m[3] = PAGE3_RST;
		sysconf_m = '0;
		memconf_m = '0;

		repeat (RST_CYC) @(negedge fclk);
		rst_n = 1'b1;
		repeat (3) @(negedge fclk);

		// address 0000 out of reset maps rom, read only
		check_flag("csrom", 1'b1, csrom);
		check_flag("rw_en", 1'b0, rw_en);
		check_flag("d_oe", 1'b0, d_oe);
		for (int w = 0; w < 4; w++) begin
			ad = addr_t'($urandom);
			ad[ADDR_W-1 -: WIN_W] = win_t'(w);
			mem_access(ad);
		end

		// every page register, then every window
		for (int r = 0; r < 4; r++)
			io_write({reg_hi(r), XT_PORT_LO}, data_t'($urandom));
		for (int w = 0; w < 4; w++) begin
			ad = addr_t'($urandom);
			ad[ADDR_W-1 -: WIN_W] = win_t'(w);
			mem_access(ad);
		end
		io_write({REG_SYSCONF, XT_PORT_LO}, data_t'($urandom));
		io_write({REG_MEMCONF, XT_PORT_LO}, data_t'($urandom));
		for (int r = 0; r < 6; r++)
			io_read({reg_hi(r), XT_PORT_LO});

		while (txn_cnt < N_TXN) begin
			kind = $urandom % 3;
			case (kind)
				0:       io_write(pick_port(), data_t'($urandom));
				1:       io_read(pick_port());
				default: mem_access(addr_t'($urandom));
			endcase
		end

		repeat (4) @(negedge fclk);
		$display("%0d transactions, %0d checks, %0d errors", txn_cnt, n_checks, n_errors);
		if (n_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/pager.sv
`timescale 1ns/1ps
`default_nettype none

module pager (
	zbus_if.map           bus,
	input  zx_pkg::page_t page_regs [4],
	input  zx_pkg::data_t memconf,
	output zx_pkg::page_t page,
	output logic          csrom,
	output logic          rw_en
);
	import zx_pkg::*;

	win_t win;
	logic win0;
	logic w0_ram;
	logic w0_we;

	////////////////////////////////////////////////////////////
	// window select
	////////////////////////////////////////////////////////////

	// 16k windows, top address bits
	assign win  = bus.a[ADDR_W-1 -: WIN_W];
	assign win0 = win == '0;

	assign page = page_regs[win];

	////////////////////////////////////////////////////////////
	// rom / ram for window 0
	////////////////////////////////////////////////////////////

	assign w0_ram = memconf[MC_W0_RAM];
	assign w0_we  = memconf[MC_W0_WE];

	// ram in window 0 only when memconf asks for it
	assign csrom = win0 & ~w0_ram;

	// rom is read only unless write-enabled
	assign rw_en = ~(csrom & ~w0_we);

endmodule

`default_nettype wire

//--- verilog/zbus_if.sv
`timescale 1ns/1ps
`default_nettype none

// z80 bus after the synchronisers
interface zbus_if;
	import zx_pkg::*;

	addr_t a;
	data_t d;

	// level, high during a synchronised io read
	logic iord;
	// one fclk wide per io write
	logic iowr_s;

	modport sync (
		output a,
		output d,
		output iord,
		output iowr_s
	);

	modport port (
		input a,
		input d,
		input iord,
		input iowr_s
	);

	modport map (
		input a
	);

endinterface

`default_nettype wire

//--- verilog/zports.sv
`timescale 1ns/1ps
`default_nettype none

module zports (
	input  logic                       fclk,
	input  logic                       rst_n,
	zbus_if.port                       bus,
	output zx_pkg::page_t              page_regs [4],
	output zx_pkg::data_t              memconf,
	output logic [zx_pkg::TURBO_W-1:0] turbo,
	output zx_pkg::data_t              d_out,
	output logic                       d_oe
);
	import zx_pkg::*;

	data_t sysconf;

	logic       xt_lo;
	data_t      hi;
	logic [3:0] sel_page;
	logic       sel_sysconf;
	logic       sel_memconf;
	logic       hit;
	data_t      rd_val;

	////////////////////////////////////////////////////////////
	// port decode
	////////////////////////////////////////////////////////////

	assign xt_lo = bus.a[7:0] == XT_PORT_LO;
	assign hi    = bus.a[ADDR_W-1:8];

	// unused high bytes at AF fall through with no select
	always_comb begin
		sel_page    = '0;
		sel_sysconf = 1'b0;
		sel_memconf = 1'b0;
		rd_val      = '0;
		if (xt_lo) begin
			case (hi)
				REG_PAGE0: begin
					sel_page[0] = 1'b1;
					rd_val      = page_regs[0];
				end
				REG_PAGE1: begin
					sel_page[1] = 1'b1;
					rd_val      = page_regs[1];
				end
				REG_PAGE2: begin
					sel_page[2] = 1'b1;
					rd_val      = page_regs[2];
				end
				REG_PAGE3: begin
					sel_page[3] = 1'b1;
					rd_val      = page_regs[3];
				end
				REG_SYSCONF: begin
					sel_sysconf = 1'b1;
					rd_val      = sysconf;
				end
				REG_MEMCONF: begin
					sel_memconf = 1'b1;
					rd_val      = memconf;
				end
				default: begin
					rd_val = '0;
				end
			endcase
		end
	end

	assign hit = |sel_page | sel_sysconf | sel_memconf;

	////////////////////////////////////////////////////////////
	// config registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			page_regs[0] <= PAGE0_RST;
			page_regs[1] <= PAGE1_RST;
			page_regs[2] <= PAGE2_RST;
			page_regs[3] <= PAGE3_RST;
			sysconf      <= '0;
			memconf      <= '0;
		end else if (bus.iowr_s) begin
			for (int i = 0; i < 4; i++) begin
				if (sel_page[i])
					page_regs[i] <= bus.d;
			end
			if (sel_sysconf)
				sysconf <= bus.d;
			if (sel_memconf)
				memconf <= bus.d;
		end
	end

	// only the clock generator would use this
	assign turbo = sysconf[TURBO_W-1:0];

	////////////////////////////////////////////////////////////
	// read back
	////////////////////////////////////////////////////////////

	assign d_out = rd_val;
	assign d_oe  = bus.iord & hit;

	// one register load per io write
	a_wr_one_cycle: assert property (@(posedge fclk) disable iff (!rst_n)
		bus.iowr_s |=> !bus.iowr_s);

endmodule

`default_nettype wire

//--- verilog/zsignals.sv
`timescale 1ns/1ps
`default_nettype none

module zsignals (
	input  logic          fclk,
	input  logic          rst_n,
	input  logic          iorq_n,
	input  logic          mreq_n,
	input  logic          rd_n,
	input  logic          wr_n,
	input  logic          m1_n,
	input  zx_pkg::addr_t a,
	input  zx_pkg::data_t d_in,
	zbus_if.sync          bus
);
	import zx_pkg::*;

	// strobes in active-high form, bit 0 is the first stage
	logic [SYNC_STAGES-1:0] iorq_q;
	logic [SYNC_STAGES-1:0] mreq_q;
	logic [SYNC_STAGES-1:0] rd_q;
	logic [SYNC_STAGES-1:0] wr_q;
	logic [SYNC_STAGES-1:0] m1_q;

	addr_t a_q [SYNC_STAGES];
	data_t d_q [SYNC_STAGES];

	logic io_cyc;
	logic iowr_lvl;
	logic iowr_lvl_d;
	logic iowr_q;

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			iorq_q <= '0;
			mreq_q <= '0;
			rd_q   <= '0;
			wr_q   <= '0;
			m1_q   <= '0;
		end else begin
			iorq_q <= {iorq_q[SYNC_STAGES-2:0], ~iorq_n};
			mreq_q <= {mreq_q[SYNC_STAGES-2:0], ~mreq_n};
			rd_q   <= {rd_q[SYNC_STAGES-2:0], ~rd_n};
			wr_q   <= {wr_q[SYNC_STAGES-2:0], ~wr_n};
			m1_q   <= {m1_q[SYNC_STAGES-2:0], ~m1_n};
		end
	end

	// address and data ride alongside the strobes
	always_ff @(posedge fclk) begin
		a_q[0] <= a;
		d_q[0] <= d_in;
		for (int i = 1; i < SYNC_STAGES; i++) begin
			a_q[i] <= a_q[i-1];
			d_q[i] <= d_q[i-1];
		end
	end

	// no io while mreq is low, and not during intack (m1)
	assign io_cyc   = iorq_q[SYNC_STAGES-1] & ~mreq_q[SYNC_STAGES-1] & ~m1_q[SYNC_STAGES-1];
	assign iowr_lvl = io_cyc & wr_q[SYNC_STAGES-1];

	// rising edge of the write condition
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			iowr_lvl_d <= 1'b0;
			iowr_q     <= 1'b0;
		end else begin
			iowr_lvl_d <= iowr_lvl;
			iowr_q     <= iowr_lvl & ~iowr_lvl_d;
		end
	end

	assign bus.a      = a_q[SYNC_STAGES-1];
	assign bus.d      = d_q[SYNC_STAGES-1];
	assign bus.iord   = io_cyc & rd_q[SYNC_STAGES-1];
	assign bus.iowr_s = iowr_q;

	a_rd_wr_excl: assert property (@(posedge fclk) disable iff (!rst_n)
		!(bus.iowr_s && bus.iord));

endmodule

`default_nettype wire

//--- verilog/zx_memctl_top.sv
`timescale 1ns/1ps
`default_nettype none

module zx_memctl_top (
	input  logic                       fclk,
	input  logic                       rst_n,

	// z80
	input  logic                       iorq_n,
	input  logic                       mreq_n,
	input  logic                       rd_n,
	input  logic                       wr_n,
	input  logic                       m1_n,
	input  zx_pkg::addr_t              a,
	input  zx_pkg::data_t              d_in,
	output zx_pkg::data_t              d_out,
	output logic                       d_oe,

	// memory paging
	output zx_pkg::page_t              page,
	output logic                       csrom,
	output logic                       rw_en,

	output logic [zx_pkg::TURBO_W-1:0] turbo
);
	import zx_pkg::*;

	page_t page_regs [4];
	data_t memconf;

	zbus_if zbus ();

	zsignals u_zsignals (
		.fclk   (fclk),
		.rst_n  (rst_n),
		.iorq_n (iorq_n),
		.mreq_n (mreq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.a      (a),
		.d_in   (d_in),
		.bus    (zbus.sync)
	);

	zports u_zports (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.bus       (zbus.port),
		.page_regs (page_regs),
		.memconf   (memconf),
		.turbo     (turbo),
		.d_out     (d_out),
		.d_oe      (d_oe)
	);

	pager u_pager (
		.bus       (zbus.map),
		.page_regs (page_regs),
		.memconf   (memconf),
		.page      (page),
		.csrom     (csrom),
		.rw_en     (rw_en)
	);

endmodule

`default_nettype wire

//--- verilog/zx_pkg.sv
`default_nettype none

package zx_pkg;

	////////////////////////////////////////////////////////////
	// bus and page widths
	////////////////////////////////////////////////////////////

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;
	localparam int PAGE_W = 8;

	// window is the top two address bits
	localparam int WIN_W = 2;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [PAGE_W-1:0] page_t;
	typedef logic [WIN_W-1:0]  win_t;

	// flops per synchroniser chain
	localparam int SYNC_STAGES = 2;

	////////////////////////////////////////////////////////////
	// extended ports, xxAF
	////////////////////////////////////////////////////////////

	localparam data_t XT_PORT_LO = 8'hAF;

	// high address byte selects the register
	localparam data_t REG_PAGE0   = 8'h10;
	localparam data_t REG_PAGE1   = 8'h11;
	localparam data_t REG_PAGE2   = 8'h12;
	localparam data_t REG_PAGE3   = 8'h13;
	localparam data_t REG_SYSCONF = 8'h20;
	localparam data_t REG_MEMCONF = 8'h21;

	// page registers after reset
	localparam page_t PAGE0_RST = 8'h00;
	localparam page_t PAGE1_RST = 8'h05;
	localparam page_t PAGE2_RST = 8'h02;
	localparam page_t PAGE3_RST = 8'h00;

	////////////////////////////////////////////////////////////
	// config register fields
	////////////////////////////////////////////////////////////

	// memconf bits for window 0
	localparam int MC_W0_WE  = 1;
	localparam int MC_W0_RAM = 3;

	// turbo lives in sysconf[1:0]
	localparam int TURBO_W = 2;

endpackage

`default_nettype wire
